/* logic/axi_burst_pkg.sv */
`default_nettype none

package axi_burst_pkg;

	// Bus and memory geometry.
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;
	localparam int ID_W = 4;
	localparam int MAX_BURST = 16;
	localparam int MEM_WORDS = 1024;
	localparam int WORD_BYTES = 4;
	localparam int WORD_IDX_W = $clog2(MEM_WORDS);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ID_W-1:0] id_t;
	// Beats minus one, as carried on AxLEN.
	typedef logic [7:0] len_t;
	typedef logic [1:0] resp_t;

	localparam resp_t OKAY = 2'b00;
	localparam resp_t SLVERR = 2'b10;

	// Address phase, shared by AW and AR.
	typedef struct packed {
		id_t id;
		addr_t addr;
		len_t len;
	} ax_chan_t;

	typedef struct packed {
		data_t data;
		logic last;
	} w_chan_t;

	typedef struct packed {
		id_t id;
		resp_t resp;
	} b_chan_t;

	typedef struct packed {
		id_t id;
		data_t data;
		resp_t resp;
		logic last;
	} r_chan_t;

	// Burst command from the outside world.
	typedef struct packed {
		logic write;
		id_t id;
		addr_t addr;
		len_t len;
	} burst_cmd_t;

	// Completion report, one per command.
	typedef struct packed {
		logic write;
		id_t id;
		resp_t resp;
	} done_t;

	typedef enum logic {ISSUE_IDLE, ISSUE_VALID} issue_state_t;
	typedef enum logic [1:0] {WD_IDLE, WD_BEATS, WD_RESP} wdata_state_t;
	typedef enum logic [1:0] {MEM_IDLE, MEM_BURST, MEM_RESP} mem_state_t;

endpackage

`default_nettype wire

/* logic/axi_aw_issuer.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_aw_issuer
	import axi_burst_pkg::*;
(
	input wire logic clk,
	input wire logic rstn,
	input wire burst_cmd_t cmd,
	input wire logic cmd_valid,
	output logic cmd_ready,
	output ax_chan_t aw,
	output logic aw_valid,
	input wire logic aw_ready,
	output len_t len,
	output id_t len_id,
	output logic len_valid,
	input wire logic len_ready
);

	issue_state_t state;
	logic cmd_take;

	// A new command needs an idle address phase and an empty length slot.
	assign cmd_ready = (state == ISSUE_IDLE) && !len_valid;
	assign cmd_take = cmd_valid && cmd_ready;
	assign aw_valid = (state == ISSUE_VALID);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ISSUE_IDLE;
			len_valid <= 1'b0;
		end else begin
			case (state)
				ISSUE_IDLE: begin
					if (cmd_take) begin
						state <= ISSUE_VALID;
					end
				end
				ISSUE_VALID: begin
					if (aw_ready) begin
						state <= ISSUE_IDLE;
					end
				end
				default: state <= ISSUE_IDLE;
			endcase

			// One-deep queue toward the data sender.
			if (cmd_take) begin
				len_valid <= 1'b1;
			end else if (len_ready) begin
				len_valid <= 1'b0;
			end
		end
	end

	// Address payload and queued length, loaded on acceptance only.
	always_ff @(posedge clk) begin
		if (cmd_take) begin
			aw <= '{id: cmd.id, addr: cmd.addr, len: cmd.len};
			len <= cmd.len;
			len_id <= cmd.id;
		end
	end

endmodule

`default_nettype wire

/* logic/axi_write_data.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_write_data
	import axi_burst_pkg::*;
(
	input wire logic clk,
	input wire logic rstn,
	input wire len_t len,
	input wire id_t len_id,
	input wire logic len_valid,
	output logic len_ready,
	input wire data_t wr_data,
	input wire logic wr_valid,
	output logic wr_ready,
	output w_chan_t w,
	output logic w_valid,
	input wire logic w_ready,
	input wire b_chan_t b,
	input wire logic b_valid,
	output logic b_ready,
	output done_t done,
	output logic done_valid,
	input wire logic done_ready
);

	wdata_state_t state;
	len_t beats_left;
	id_t cur_id;
	logic in_beats;
	logic w_fire;

	assign in_beats = (state == WD_BEATS);
	assign len_ready = (state == WD_IDLE);

	// The external stream is passed straight onto W during a burst.
	assign w_valid = in_beats && wr_valid;
	assign wr_ready = in_beats && w_ready;
	assign w_fire = w_valid && w_ready;

	always_comb begin
		w.data = wr_data;
		w.last = (beats_left == '0);
	end

	// No new B while an earlier completion still waits in the merge.
	assign b_ready = (state == WD_RESP) && !done_valid;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= WD_IDLE;
			done_valid <= 1'b0;
		end else begin
			case (state)
				WD_IDLE: begin
					if (len_valid) begin
						state <= WD_BEATS;
					end
				end
				WD_BEATS: begin
					if (w_fire && w.last) begin
						state <= WD_RESP;
					end
				end
				WD_RESP: begin
					if (b_valid && b_ready) begin
						state <= WD_IDLE;
					end
				end
				default: state <= WD_IDLE;
			endcase

			if (b_valid && b_ready) begin
				done_valid <= 1'b1;
			end else if (done_ready) begin
				done_valid <= 1'b0;
			end
		end
	end

	// Beat counter and completion payload.
	always_ff @(posedge clk) begin
		if (len_valid && len_ready) begin
			beats_left <= len;
			cur_id <= len_id;
		end else if (w_fire) begin
			beats_left <= beats_left - 8'd1;
		end

		if (b_valid && b_ready) begin
			done <= '{write: 1'b1, id: cur_id, resp: b.resp};
		end
	end

endmodule

`default_nettype wire

/* logic/axi_read_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine
	import axi_burst_pkg::*;
(
	input wire logic clk,
	input wire logic rstn,
	input wire burst_cmd_t cmd,
	input wire logic cmd_valid,
	output logic cmd_ready,
	output ax_chan_t ar,
	output logic ar_valid,
	input wire logic ar_ready,
	input wire r_chan_t r,
	input wire logic r_valid,
	output logic r_ready,
	output data_t rd_data,
	output logic rd_last,
	output logic rd_valid,
	input wire logic rd_ready,
	output done_t done,
	output logic done_valid,
	input wire logic done_ready
);

	issue_state_t addr_state;
	logic busy;
	id_t cur_id;
	resp_t worst;
	resp_t final_resp;
	logic cmd_take;
	logic r_fire;

	// One burst at a time; the next waits until the completion has left.
	assign cmd_ready = (addr_state == ISSUE_IDLE) && !busy && !done_valid;
	assign cmd_take = cmd_valid && cmd_ready;
	assign ar_valid = (addr_state == ISSUE_VALID);

	// R passes through to the read port.
	assign rd_valid = busy && r_valid;
	assign r_ready = busy && rd_ready;
	assign rd_data = r.data;
	assign rd_last = r.last;
	assign r_fire = r_valid && r_ready;

	// SLVERR outranks OKAY.
	assign final_resp = (r.resp > worst) ? r.resp : worst;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			addr_state <= ISSUE_IDLE;
			busy <= 1'b0;
			done_valid <= 1'b0;
		end else begin
			case (addr_state)
				ISSUE_IDLE: begin
					if (cmd_take) begin
						addr_state <= ISSUE_VALID;
					end
				end
				ISSUE_VALID: begin
					if (ar_ready) begin
						addr_state <= ISSUE_IDLE;
					end
				end
				default: addr_state <= ISSUE_IDLE;
			endcase

			if (cmd_take) begin
				busy <= 1'b1;
			end else if (r_fire && r.last) begin
				busy <= 1'b0;
			end

			if (r_fire && r.last) begin
				done_valid <= 1'b1;
			end else if (done_ready) begin
				done_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take) begin
			ar <= '{id: cmd.id, addr: cmd.addr, len: cmd.len};
			cur_id <= cmd.id;
			worst <= OKAY;
		end else if (r_fire) begin
			worst <= final_resp;
		end

		if (r_fire && r.last) begin
			done <= '{write: 1'b0, id: cur_id, resp: final_resp};
		end
	end

endmodule

`default_nettype wire

/* logic/axi_burst_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_memory
	import axi_burst_pkg::*;
(
	input wire logic clk,
	input wire logic rstn,
	input wire ax_chan_t aw,
	input wire logic aw_valid,
	output logic aw_ready,
	input wire w_chan_t w,
	input wire logic w_valid,
	output logic w_ready,
	output b_chan_t b,
	output logic b_valid,
	input wire logic b_ready,
	input wire ax_chan_t ar,
	input wire logic ar_valid,
	output logic ar_ready,
	output r_chan_t r,
	output logic r_valid,
	input wire logic r_ready
);

	data_t mem [MEM_WORDS];

	mem_state_t wstate;
	mem_state_t rstate;

	logic [WORD_IDX_W-1:0] w_idx;
	id_t w_id;
	logic w_err;

	logic [WORD_IDX_W-1:0] r_idx;
	id_t r_id;
	logic r_err;
	len_t r_left;

	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic r_fire;

	// True when the last beat of the burst lands past the end of memory.
	function automatic logic out_of_range(ax_chan_t ax);
		logic [ADDR_W:0] last_idx;
		last_idx = (ADDR_W+1)'(ax.addr / WORD_BYTES) + (ADDR_W+1)'(ax.len);
		return last_idx >= (ADDR_W+1)'(MEM_WORDS);
	endfunction

	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;
	assign ar_fire = ar_valid && ar_ready;
	assign r_fire = r_valid && r_ready;

	assign w_ready = (wstate == MEM_BURST);
	assign b_valid = (wstate == MEM_RESP);
	assign r_valid = (rstate == MEM_BURST);

	always_comb begin
		b.id = w_id;
		b.resp = w_err ? SLVERR : OKAY;
	end

	// Out-of-range reads return zero on every beat.
	always_comb begin
		r.id = r_id;
		r.data = r_err ? '0 : mem[r_idx];
		r.resp = r_err ? SLVERR : OKAY;
		r.last = (r_left == '0);
	end

	// Write side: AW, then beats up to WLAST, then B.
	always_ff @(posedge clk) begin
		if (!rstn) begin
			wstate <= MEM_IDLE;
			aw_ready <= 1'b0;
		end else begin
			case (wstate)
				MEM_IDLE: begin
					// Ready one cycle after valid, dropped after the transfer.
					aw_ready <= aw_valid && !aw_ready;
					if (aw_fire) begin
						wstate <= MEM_BURST;
					end
				end
				MEM_BURST: begin
					if (w_fire && w.last) begin
						wstate <= MEM_RESP;
					end
				end
				MEM_RESP: begin
					if (b_ready) begin
						wstate <= MEM_IDLE;
					end
				end
				default: wstate <= MEM_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			w_idx <= WORD_IDX_W'(aw.addr / WORD_BYTES);
			w_id <= aw.id;
			w_err <= out_of_range(aw);
		end else if (w_fire) begin
			w_idx <= w_idx + 1'b1;
		end

		if (w_fire && !w_err) begin
			mem[w_idx] <= w.data;
		end
	end

	// Read side: AR, then len+1 beats.
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rstate <= MEM_IDLE;
			ar_ready <= 1'b0;
		end else begin
			case (rstate)
				MEM_IDLE: begin
					ar_ready <= ar_valid && !ar_ready;
					if (ar_fire) begin
						rstate <= MEM_BURST;
					end
				end
				MEM_BURST: begin
					if (r_fire && r.last) begin
						rstate <= MEM_IDLE;
					end
				end
				default: rstate <= MEM_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			r_idx <= WORD_IDX_W'(ar.addr / WORD_BYTES);
			r_id <= ar.id;
			r_err <= out_of_range(ar);
			r_left <= ar.len;
		end else if (r_fire) begin
			r_idx <= r_idx + 1'b1;
			r_left <= r_left - 8'd1;
		end
	end

endmodule

`default_nettype wire

/* logic/axi_burst_system.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_system
	import axi_burst_pkg::*;
(
	input wire logic clk,
	input wire logic rstn,
	input wire burst_cmd_t cmd,
	input wire logic cmd_valid,
	output logic cmd_ready,
	input wire data_t wr_data,
	input wire logic wr_valid,
	output logic wr_ready,
	output data_t rd_data,
	output logic rd_last,
	output logic rd_valid,
	input wire logic rd_ready,
	output done_t done,
	output logic done_valid
);

	ax_chan_t aw;
	logic aw_valid;
	logic aw_ready;
	w_chan_t w;
	logic w_valid;
	logic w_ready;
	b_chan_t b;
	logic b_valid;
	logic b_ready;
	ax_chan_t ar;
	logic ar_valid;
	logic ar_ready;
	r_chan_t r;
	logic r_valid;
	logic r_ready;

	logic wcmd_valid;
	logic wcmd_ready;
	logic rcmd_valid;
	logic rcmd_ready;

	len_t len;
	id_t len_id;
	logic len_valid;
	logic len_ready;

	done_t wr_done;
	logic wr_done_valid;
	done_t rd_done;
	logic rd_done_valid;
	logic rd_done_ready;

	// Commands go to one side by the write flag.
	assign wcmd_valid = cmd_valid && cmd.write;
	assign rcmd_valid = cmd_valid && !cmd.write;
	assign cmd_ready = cmd.write ? wcmd_ready : rcmd_ready;

	// Fixed priority, write first. A read completion waits a cycle.
	assign done_valid = wr_done_valid || rd_done_valid;
	assign done = wr_done_valid ? wr_done : rd_done;
	assign rd_done_ready = !wr_done_valid;

	axi_aw_issuer aw_iss0 (
		.clk(clk),
		.rstn(rstn),
		.cmd(cmd),
		.cmd_valid(wcmd_valid),
		.cmd_ready(wcmd_ready),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.len(len),
		.len_id(len_id),
		.len_valid(len_valid),
		.len_ready(len_ready)
	);

	axi_write_data wdat0 (
		.clk(clk),
		.rstn(rstn),
		.len(len),
		.len_id(len_id),
		.len_valid(len_valid),
		.len_ready(len_ready),
		.wr_data(wr_data),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b(b),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.done(wr_done),
		.done_valid(wr_done_valid),
		.done_ready(1'b1)
	);

	axi_read_engine rd0 (
		.clk(clk),
		.rstn(rstn),
		.cmd(cmd),
		.cmd_valid(rcmd_valid),
		.cmd_ready(rcmd_ready),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.rd_data(rd_data),
		.rd_last(rd_last),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.done(rd_done),
		.done_valid(rd_done_valid),
		.done_ready(rd_done_ready)
	);

	axi_burst_memory mem0 (
		.clk(clk),
		.rstn(rstn),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b(b),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready)
	);

endmodule

`default_nettype wire

/* sim/axi_burst_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_checker
	import axi_burst_pkg::*;
(
	input wire logic clk,
	input wire logic rstn,
	input wire data_t rd_data,
	input wire logic rd_last,
	input wire logic rd_valid,
	input wire logic rd_ready,
	input wire done_t done,
	input wire logic done_valid
);

	data_t exp_data[$];
	logic exp_last[$];
	done_t exp_done[$];
	int errors = 0;

	task automatic expect_beat(input data_t data, input logic last);
		exp_data.push_back(data);
		exp_last.push_back(last);
	endtask

	task automatic expect_done(input done_t d);
		exp_done.push_back(d);
	endtask

	function automatic int outstanding();
		return exp_data.size() + exp_done.size();
	endfunction

	// Sampled mid-cycle, where the handshake for the next edge is settled.
	always @(negedge clk) begin
		if (rstn && rd_valid && rd_ready) begin
			if (exp_data.size() == 0) begin
				$display("Read beat %h arrived while no beat was expected", rd_data);
				errors++;
			end else begin
				if (rd_data !== exp_data[0]) begin
					$display("ERROR rd_data got %h expected %h", rd_data, exp_data[0]);
					errors++;
				end
				if (rd_last !== exp_last[0]) begin
					$display("ERROR rd_last got %h expected %h", rd_last, exp_last[0]);
					errors++;
				end
				void'(exp_data.pop_front());
				void'(exp_last.pop_front());
			end
		end

		// The merge presents one completion per cycle of done_valid.
		if (rstn && done_valid) begin
			if (exp_done.size() == 0) begin
				$display("Completion %h arrived while none was expected", done);
				errors++;
			end else begin
				if (done !== exp_done[0]) begin
					$display("ERROR done got %h expected %h", done, exp_done[0]);
					errors++;
				end
				void'(exp_done.pop_front());
			end
		end
	end

endmodule

`default_nettype wire

/* sim/axi_burst_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_properties
	import axi_burst_pkg::*;
(
	input wire logic clk,
	input wire logic rstn,
	input wire ax_chan_t aw,
	input wire logic aw_valid,
	input wire logic aw_ready,
	input wire ax_chan_t ar,
	input wire logic ar_valid,
	input wire logic ar_ready,
	input wire r_chan_t r,
	input wire logic r_valid,
	input wire logic r_ready,
	input wire w_chan_t w,
	input wire logic w_valid,
	input wire logic w_ready
);

	int violations = 0;

	// A stalled source keeps valid high and its payload unchanged.
	aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
	else begin
		$error("AW valid dropped or payload changed while stalled");
		violations++;
	end

	ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
	else begin
		$error("AR valid dropped or payload changed while stalled");
		violations++;
	end

	r_hold: assert property (@(posedge clk) disable iff (!rstn)
		r_valid && !r_ready |=> r_valid && $stable(r))
	else begin
		$error("R valid dropped or payload changed while stalled");
		violations++;
	end

	// A write beat waits on W until the memory takes it.
	w_hold: assert property (@(posedge clk) disable iff (!rstn)
		w_valid && !w_ready |=> w_valid && $stable(w))
	else begin
		$error("W valid dropped or payload changed while stalled");
		violations++;
	end

endmodule

bind axi_burst_memory axi_burst_properties props0 (
	.clk(clk),
	.rstn(rstn),
	.aw(aw),
	.aw_valid(aw_valid),
	.aw_ready(aw_ready),
	.ar(ar),
	.ar_valid(ar_valid),
	.ar_ready(ar_ready),
	.r(r),
	.r_valid(r_valid),
	.r_ready(r_ready),
	.w(w),
	.w_valid(w_valid),
	.w_ready(w_ready)
);

`default_nettype wire

/* sim/axi_burst_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_tb
	import axi_burst_pkg::*;
();

	logic clk;
	logic rstn;
	burst_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	data_t wr_data;
	logic wr_valid;
	logic wr_ready;
	data_t rd_data;
	logic rd_last;
	logic rd_valid;
	logic rd_ready;
	done_t done;
	logic done_valid;

	int seed = 32'h56ae;
	int stall_seed = 32'h56ae;
	logic stall_en;
	data_t wr_q[$];
	data_t model [MEM_WORDS];
	int tb_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errs_at_start = 0;

	axi_burst_system dut0 (
		.clk(clk),
		.rstn(rstn),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.wr_data(wr_data),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.rd_data(rd_data),
		.rd_last(rd_last),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.done(done),
		.done_valid(done_valid)
	);

	axi_burst_checker chk0 (
		.clk(clk),
		.rstn(rstn),
		.rd_data(rd_data),
		.rd_last(rd_last),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.done(done),
		.done_valid(done_valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reference model. A burst whose last word is past the end gets SLVERR and zeros.
	function automatic resp_t burst_resp(input int word, input int beats);
		return (word + beats - 1 >= MEM_WORDS) ? SLVERR : OKAY;
	endfunction

	function automatic data_t ref_data(input int word, input int beats, input int beat);
		if (burst_resp(word, beats) == SLVERR) begin
			return '0;
		end
		return model[WORD_IDX_W'(word + beat)];
	endfunction

	function automatic int rand_word();
		return $unsigned($random(seed)) % (MEM_WORDS - 32);
	endfunction

	function automatic int total_errors();
		return chk0.errors + tb_errors + dut0.mem0.props0.violations;
	endfunction

	task automatic send_cmd(input logic write, input id_t id, input int word, input int beats);
		cmd.write = write;
		cmd.id = id;
		cmd.addr = addr_t'(word * WORD_BYTES);
		cmd.len = len_t'(beats - 1);
		cmd_valid = 1'b1;
		@(negedge clk);
		while (!cmd_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	task automatic write_burst(input id_t id, input int word, input int beats);
		resp_t resp;
		data_t d;
		done_t exp;
		int i;
		resp = burst_resp(word, beats);
		for (i = 0; i < beats; i++) begin
			d = $random(seed);
			wr_q.push_back(d);
			if (resp == OKAY) begin
				model[WORD_IDX_W'(word + i)] = d;
			end
		end
		exp.write = 1'b1;
		exp.id = id;
		exp.resp = resp;
		chk0.expect_done(exp);
		send_cmd(1'b1, id, word, beats);
	endtask

	task automatic read_burst(input id_t id, input int word, input int beats);
		done_t exp;
		int i;
		for (i = 0; i < beats; i++) begin
			chk0.expect_beat(ref_data(word, beats, i), i == beats - 1);
		end
		exp.write = 1'b0;
		exp.id = id;
		exp.resp = burst_resp(word, beats);
		chk0.expect_done(exp);
		send_cmd(1'b0, id, word, beats);
	endtask

	task automatic wait_idle(input string what);
		int n;
		n = 0;
		while ((chk0.outstanding() != 0 || wr_q.size() != 0) && n < 400) begin
			@(posedge clk);
			n++;
		end
		if (n >= 400) begin
			$display("%s did not finish within 400 cycles", what);
			tb_errors++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = total_errors() - errs_at_start;
		tests_run++;
		if (errs == 0) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			$display("Test %0d %s: %0d errors", tests_run, name, errs);
			tests_failed++;
		end
		errs_at_start = total_errors();
	endtask

	// Write data stream, consumed in command order.
	initial begin : wr_driver
		logic fire;
		wr_valid = 1'b0;
		wr_data = '0;
		forever begin
			@(negedge clk);
			fire = wr_valid && wr_ready;
			@(posedge clk);
			#1;
			if (fire) begin
				void'(wr_q.pop_front());
			end
			wr_valid = (wr_q.size() != 0);
			wr_data = (wr_q.size() != 0) ? wr_q[0] : '0;
		end
	end

	initial begin : rd_ready_driver
		int r;
		rd_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			r = $random(stall_seed);
			rd_ready = !stall_en || r[0];
		end
	end

	initial begin : watchdog
		int limit;
		// Total beats of all tests, 40 cycles each, plus a margin.
		limit = (2 + 32 + 32 + 40 + 24) * 40 + 500;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles with tests still running", limit);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : main
		int a;
		int b;
		cmd = '0;
		cmd_valid = 1'b0;
		stall_en = 1'b0;
		rstn = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rstn = 1'b1;

		a = rand_word();
		write_burst(4'h1, a, 1);
		wait_idle("Single beat write");
		read_burst(4'h2, a, 1);
		wait_idle("Single beat read");
		end_test("single beat");

		a = rand_word();
		write_burst(4'h3, a, 16);
		wait_idle("Long write");
		read_burst(4'h4, a, 16);
		wait_idle("Long read");
		end_test("16-beat burst");

		// The second address phase runs ahead of the first burst's data.
		a = rand_word();
		b = rand_word();
		write_burst(4'h5, a, 8);
		write_burst(4'h6, b, 8);
		if (wr_q.size() <= 8) begin
			$display("Second write was accepted only after the first burst's data had gone");
			tb_errors++;
		end
		wait_idle("Back-to-back writes");
		read_burst(4'h7, a, 8);
		read_burst(4'h8, b, 8);
		wait_idle("Back-to-back read back");
		end_test("back-to-back writes");

		a = rand_word();
		write_burst(4'h9, a, 16);
		wait_idle("Stall test write");
		stall_en = 1'b1;
		read_burst(4'ha, a, 16);
		read_burst(4'hb, a + 4, 8);
		wait_idle("Stalled reads");
		stall_en = 1'b0;
		end_test("read stalls");

		write_burst(4'hc, MEM_WORDS - 4, 4);
		wait_idle("Tail write");
		write_burst(4'hd, MEM_WORDS - 4, 8);
		wait_idle("Crossing write");
		read_burst(4'he, MEM_WORDS - 4, 4);
		read_burst(4'hf, MEM_WORDS - 4, 8);
		wait_idle("Tail reads");
		end_test("end of memory");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* axi_burst.f */
logic/axi_burst_pkg.sv
logic/axi_aw_issuer.sv
logic/axi_write_data.sv
logic/axi_read_engine.sv
logic/axi_burst_memory.sv
logic/axi_burst_system.sv
sim/axi_burst_checker.sv
sim/axi_burst_properties.sv
sim/axi_burst_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module axi_burst_tb -f axi_burst.f \
	&& ./obj_dir/Vaxi_burst_tb +verilator+error+limit+100 | tee /dev/stderr \
	| grep -F -x '>>> PASS' > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
